// File: common/CoreTypesPkg.sv
package CoreTypesPkg;

    // Architectural register file, register 0 is hardwired and never renamed
    localparam int RegIdWidth = 4;

    // Physical register file
    localparam int TagWidth = 5;

    // Program-order sequence number, wraps around
    localparam int SqNWidth = 6;

    localparam int NumRegs = 1 << RegIdWidth;
    localparam int NumTags = 1 << TagWidth;

    // Architectural register number
    typedef logic [RegIdWidth-1:0] RegId;

    // Physical register tag
    typedef logic [TagWidth-1:0] Tag;

    // Sequence number
    // Compare two of these by the sign of their difference, never directly
    typedef logic [SqNWidth-1:0] SqN;

endpackage

// File: common/UopPkg.sv
package UopPkg;

    // Functional unit that executes the op, passed through rename unchanged
    typedef enum logic [2:0] {
        FuAlu    = 3'd0,
        FuMul    = 3'd1,
        FuLsu    = 3'd2,
        FuSt     = 3'd3,
        FuBranch = 3'd4
    } FuncUnit;

    // Immediate operand as produced by decode
    typedef logic [31:0] Imm;

endpackage

// File: rename/RenameTable.sv
`timescale 1ns/1ps

module RenameTable #(
    parameter int WidthUops = 2,
    parameter int WidthWb = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,

    input  CoreTypesPkg::RegId  lookupRegs[2*WidthUops],
    output CoreTypesPkg::Tag    lookupTag[2*WidthUops],
    output logic                lookupAvail[2*WidthUops],

    input  logic                issueValid[WidthUops],
    input  CoreTypesPkg::RegId  issueRegs[WidthUops],
    input  CoreTypesPkg::Tag    issueTags[WidthUops],

    input  logic                commitValid[WidthUops],
    input  CoreTypesPkg::RegId  commitRegs[WidthUops],
    input  CoreTypesPkg::Tag    commitTags[WidthUops],
    output CoreTypesPkg::Tag    commitPrevTags[WidthUops],

    input  logic                wbValid[WidthWb],
    input  CoreTypesPkg::Tag    wbTag[WidthWb]
);
    import CoreTypesPkg::*;

    Tag specMap[NumRegs];
    Tag comMap[NumRegs];
    logic [NumTags-1:0] ready;

    Tag nextSpecMap[NumRegs];
    Tag nextComMap[NumRegs];
    logic [NumTags-1:0] nextReady;

    // Source lookup, two sources per op
    always_comb begin
        for (int l = 0; l < 2 * WidthUops; l++) begin
            lookupTag[l] = specMap[lookupRegs[l]];
            lookupAvail[l] = ready[lookupTag[l]];
            // Result arriving this cycle
            for (int w = 0; w < WidthWb; w++) begin
                if (wbValid[w] && wbTag[w] == lookupTag[l])
                    lookupAvail[l] = 1'b1;
            end
            // Older op in the same bundle writes this register
            for (int j = 0; j < l / 2; j++) begin
                if (issueValid[j] && issueRegs[j] != '0 && issueRegs[j] == lookupRegs[l]) begin
                    lookupTag[l] = issueTags[j];
                    lookupAvail[l] = 1'b0;
                end
            end
        end
    end

    // Previous committed tag, chained across lanes of one commit bundle
    always_comb begin
        for (int i = 0; i < WidthUops; i++) begin
            commitPrevTags[i] = comMap[commitRegs[i]];
            for (int j = 0; j < i; j++) begin
                if (commitValid[j] && commitRegs[j] == commitRegs[i])
                    commitPrevTags[i] = commitTags[j];
            end
        end
    end

    always_comb begin
        nextComMap = comMap;
        nextSpecMap = specMap;
        nextReady = ready;
        // Later lanes overwrite earlier ones
        for (int i = 0; i < WidthUops; i++) begin
            if (commitValid[i])
                nextComMap[commitRegs[i]] = commitTags[i];
        end
        if (flush) begin
            nextSpecMap = nextComMap;
        end else begin
            for (int i = 0; i < WidthUops; i++) begin
                if (issueValid[i] && issueRegs[i] != '0) begin
                    nextSpecMap[issueRegs[i]] = issueTags[i];
                    nextReady[issueTags[i]] = 1'b0;
                end
            end
        end
        for (int w = 0; w < WidthWb; w++) begin
            if (wbValid[w])
                nextReady[wbTag[w]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, every register holds a ready value
            for (int r = 0; r < NumRegs; r++) begin
                specMap[r] <= Tag'(r);
                comMap[r] <= Tag'(r);
            end
            ready <= '1;
        end else begin
            specMap <= nextSpecMap;
            comMap <= nextComMap;
            ready <= nextReady;
        end
    end

endmodule

// File: rename/TagBuffer.sv
`timescale 1ns/1ps

module TagBuffer #(
    parameter int WidthUops = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,

    input  logic              allocValid[WidthUops],
    output CoreTypesPkg::Tag  allocTags[WidthUops],
    output logic              allocOk[WidthUops],

    input  logic              commitValid[WidthUops],
    input  CoreTypesPkg::Tag  commitTags[WidthUops],
    input  CoreTypesPkg::Tag  commitPrevTags[WidthUops]
);
    import CoreTypesPkg::*;

    // Tags in use by the speculative and by the committed state
    logic [NumTags-1:0] specOwned;
    logic [NumTags-1:0] comOwned;

    logic [NumTags-1:0] taken;
    logic allGranted;
    logic [NumTags-1:0] nextSpec;
    logic [NumTags-1:0] nextCom;

    // Lowest free tag per requesting lane, in lane order
    always_comb begin
        taken = specOwned;
        allGranted = 1'b1;
        for (int i = 0; i < WidthUops; i++) begin
            allocTags[i] = '0;
            allocOk[i] = 1'b0;
            // Scan downwards so the lowest free tag wins
            for (int t = NumTags - 1; t >= 0; t--) begin
                if (!taken[t]) begin
                    allocTags[i] = Tag'(t);
                    allocOk[i] = 1'b1;
                end
            end
            if (allocValid[i]) begin
                if (allocOk[i])
                    taken[allocTags[i]] = 1'b1;
                else
                    allGranted = 1'b0;
            end
        end
    end

    always_comb begin
        // Bundle claims its tags only when every lane was granted
        nextSpec = allGranted ? taken : specOwned;
        nextCom = comOwned;
        for (int i = 0; i < WidthUops; i++) begin
            if (commitValid[i]) begin
                nextCom[commitTags[i]] = 1'b1;
                nextCom[commitPrevTags[i]] = 1'b0;
                nextSpec[commitPrevTags[i]] = 1'b0;
            end
        end
        if (flush)
            nextSpec = nextCom;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            specOwned <= {{(NumTags - NumRegs){1'b0}}, {NumRegs{1'b1}}};
            comOwned <= {{(NumTags - NumRegs){1'b0}}, {NumRegs{1'b1}}};
        end else begin
            specOwned <= nextSpec;
            comOwned <= nextCom;
        end
    end

endmodule

// File: rename/Rename.sv
`timescale 1ns/1ps

module Rename #(
    parameter int WidthUops = 2,
    parameter int WidthWb = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic                flush,
    input  CoreTypesPkg::SqN    flushSqN,

    // Decoded bundle
    input  logic                uopValid[WidthUops],
    input  CoreTypesPkg::RegId  uopRs0[WidthUops],
    input  CoreTypesPkg::RegId  uopRs1[WidthUops],
    input  CoreTypesPkg::RegId  uopRd[WidthUops],
    input  UopPkg::FuncUnit     uopFu[WidthUops],
    input  UopPkg::Imm          uopImm[WidthUops],

    // Commit lanes from the ROB, in program order
    input  logic                comValid[WidthUops],
    input  CoreTypesPkg::RegId  comRd[WidthUops],
    input  CoreTypesPkg::Tag    comTag[WidthUops],

    input  logic                wbValid[WidthWb],
    input  CoreTypesPkg::Tag    wbTag[WidthWb],

    output logic                stall,

    output logic                outValid[WidthUops],
    output CoreTypesPkg::SqN    outSqN[WidthUops],
    output CoreTypesPkg::Tag    outTagA[WidthUops],
    output CoreTypesPkg::Tag    outTagB[WidthUops],
    output CoreTypesPkg::Tag    outTagDst[WidthUops],
    output logic                outAvailA[WidthUops],
    output logic                outAvailB[WidthUops],
    output CoreTypesPkg::RegId  outRd[WidthUops],
    output UopPkg::FuncUnit     outFu[WidthUops],
    output UopPkg::Imm          outImm[WidthUops],

    output CoreTypesPkg::SqN    nextSqN
);
    import CoreTypesPkg::*;

    logic accept;
    logic allocValid[WidthUops];
    Tag allocTags[WidthUops];
    logic allocOk[WidthUops];

    RegId lookupRegs[2*WidthUops];
    Tag lookupTag[2*WidthUops];
    logic lookupAvail[2*WidthUops];

    logic issueValid[WidthUops];
    logic commitValid[WidthUops];
    Tag commitPrevTags[WidthUops];

    SqN counterSqN;
    SqN laneSqN[WidthUops];
    SqN counterNext;

    // Tag requests only for ops that write a real register
    always_comb begin
        for (int i = 0; i < WidthUops; i++)
            allocValid[i] = en && !flush && uopValid[i] && uopRd[i] != '0;
    end

    always_comb begin
        stall = 1'b0;
        for (int i = 0; i < WidthUops; i++) begin
            if (allocValid[i] && !allocOk[i])
                stall = 1'b1;
        end
    end

    assign accept = en && !flush && !stall;

    always_comb begin
        counterNext = counterSqN;
        for (int i = 0; i < WidthUops; i++) begin
            lookupRegs[2*i] = uopRs0[i];
            lookupRegs[2*i+1] = uopRs1[i];
            issueValid[i] = accept && uopValid[i];
            commitValid[i] = comValid[i] && comRd[i] != '0;
            laneSqN[i] = counterNext;
            if (uopValid[i])
                counterNext = counterNext + SqN'(1);
        end
    end

    assign nextSqN = counterSqN;

    RenameTable #(
        .WidthUops(WidthUops),
        .WidthWb(WidthWb)
    ) table_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .lookupRegs(lookupRegs),
        .lookupTag(lookupTag),
        .lookupAvail(lookupAvail),
        .issueValid(issueValid),
        .issueRegs(uopRd),
        .issueTags(allocTags),
        .commitValid(commitValid),
        .commitRegs(comRd),
        .commitTags(comTag),
        .commitPrevTags(commitPrevTags),
        .wbValid(wbValid),
        .wbTag(wbTag)
    );

    TagBuffer #(
        .WidthUops(WidthUops)
    ) tagBuf_i (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .allocValid(allocValid),
        .allocTags(allocTags),
        .allocOk(allocOk),
        .commitValid(commitValid),
        .commitTags(comTag),
        .commitPrevTags(commitPrevTags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            counterSqN <= '0;
            for (int i = 0; i < WidthUops; i++)
                outValid[i] <= 1'b0;
        end else if (flush) begin
            // Restart numbering right after the mispredicted branch
            counterSqN <= flushSqN + SqN'(1);
            for (int i = 0; i < WidthUops; i++)
                outValid[i] <= 1'b0;
        end else if (accept) begin
            for (int i = 0; i < WidthUops; i++) begin
                outValid[i] <= uopValid[i];
                outSqN[i] <= laneSqN[i];
                outTagA[i] <= lookupTag[2*i];
                outTagB[i] <= lookupTag[2*i+1];
                outAvailA[i] <= lookupAvail[2*i];
                outAvailB[i] <= lookupAvail[2*i+1];
                outTagDst[i] <= (uopRd[i] != '0) ? allocTags[i] : '0;
                outRd[i] <= uopRd[i];
                outFu[i] <= uopFu[i];
                outImm[i] <= uopImm[i];
            end
            counterSqN <= counterNext;
        end else begin
            if (!en) begin
                for (int i = 0; i < WidthUops; i++)
                    outValid[i] <= 1'b0;
            end
            // Held bundle is read later, keep its operand ready bits current
            for (int w = 0; w < WidthWb; w++) begin
                for (int i = 0; i < WidthUops; i++) begin
                    if (wbValid[w] && outTagA[i] == wbTag[w])
                        outAvailA[i] <= 1'b1;
                    if (wbValid[w] && outTagB[i] == wbTag[w])
                        outAvailB[i] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: tests/Rename_sva.sv
`timescale 1ns/1ps

module Rename_sva #(
    parameter int WidthUops = 2
) (
    input logic               clk,
    input logic               rst,
    input logic               flush,
    input logic               stall,
    input logic               outValid[WidthUops],
    input CoreTypesPkg::Tag   outTagDst[WidthUops],
    input CoreTypesPkg::RegId outRd[WidthUops],
    input CoreTypesPkg::SqN   outSqN[WidthUops]
);
    for (genvar i = 0; i < WidthUops; i++) begin : g_lane
        // Flushed bundle never reaches the outputs
        flushClears: assert property (@(posedge clk) disable iff (rst)
            flush |=> !outValid[i])
            else $error("outValid set after flush, lane %0d", i);

        // Tag 0 belongs to register 0 and is never handed out
        dstTagLegal: assert property (@(posedge clk) disable iff (rst)
            (outValid[i] && outRd[i] != '0) |-> outTagDst[i] != '0)
            else $error("Tag 0 given to a renamed destination, lane %0d", i);

        stallHolds: assert property (@(posedge clk) disable iff (rst)
            stall |=> ($stable(outValid[i]) && $stable(outTagDst[i]) && $stable(outSqN[i])))
            else $error("Outputs changed under stall, lane %0d", i);
    end

endmodule

bind Rename Rename_sva #(.WidthUops(WidthUops)) sva_i (
    .clk(clk), .rst(rst), .flush(flush), .stall(stall), .outValid(outValid),
    .outTagDst(outTagDst), .outRd(outRd), .outSqN(outSqN)
);

// File: tests/Rename_tb.sv
`timescale 1ns/1ps

module Rename_tb;
    import CoreTypesPkg::*;
    import UopPkg::*;

    localparam int Lanes = 2;
    // Rough length of all tests in cycles
    localparam int TestCycles = 60;

    logic clk, rst, en, flush;
    SqN flushSqN, nextSqN;
    logic uopValid[Lanes], comValid[Lanes], wbValid[Lanes];
    RegId uopRs0[Lanes], uopRs1[Lanes], uopRd[Lanes], comRd[Lanes];
    FuncUnit uopFu[Lanes];
    Imm uopImm[Lanes];
    Tag comTag[Lanes], wbTag[Lanes];
    logic stall;
    logic outValid[Lanes], outAvailA[Lanes], outAvailB[Lanes];
    SqN outSqN[Lanes];
    Tag outTagA[Lanes], outTagB[Lanes], outTagDst[Lanes];
    RegId outRd[Lanes];
    FuncUnit outFu[Lanes];
    Imm outImm[Lanes];

    // Reference state
    Tag mSpec[NumRegs], mCom[NumRegs];
    logic [NumTags-1:0] mReady, mSpecOwn, mComOwn;
    SqN mCounter;
    logic eLoaded, eValid[Lanes], eAvailA[Lanes], eAvailB[Lanes];
    SqN eSqN[Lanes];
    Tag eTagA[Lanes], eTagB[Lanes], eTagDst[Lanes];
    RegId eRd[Lanes];
    FuncUnit eFu[Lanes];
    Imm eImm[Lanes];
    RegId robRd[$];
    Tag robTag[$];

    logic [31:0] lfsr;
    int errors, checks, tests, cycles;
    string testName;

    Rename #(.WidthUops(Lanes), .WidthWb(Lanes)) dut_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Lowest free tags for the ops that name a destination
    function automatic logic grantTags(output Tag tags[Lanes]);
        logic [NumTags-1:0] owned;
        logic found;
        owned = mSpecOwn;
        for (int i = 0; i < Lanes; i++) begin
            tags[i] = '0;
            if (uopValid[i] && uopRd[i] != '0) begin
                found = 1'b0;
                for (int t = 0; t < NumTags && !found; t++) begin
                    if (!owned[t]) begin
                        tags[i] = Tag'(t);
                        owned[t] = 1'b1;
                        found = 1'b1;
                    end
                end
                if (!found)
                    return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic expStall();
        Tag tags[Lanes];
        return en && !flush && !grantTags(tags);
    endfunction

    function automatic void resetModel();
        for (int r = 0; r < NumRegs; r++) begin
            mSpec[r] = Tag'(r);
            mCom[r] = Tag'(r);
        end
        mReady = '1;
        mSpecOwn = {{(NumTags - NumRegs){1'b0}}, {NumRegs{1'b1}}};
        mComOwn = mSpecOwn;
        mCounter = '0;
        eLoaded = 1'b0;
        eValid = '{default: 1'b0};
        robRd.delete();
        robTag.delete();
    endfunction

    // Applies one clock edge to the reference state
    function automatic void stepModel();
        Tag tags[Lanes];
        logic accept;
        logic [NumTags-1:0] rdy;
        Tag prev;
        accept = en && !flush && grantTags(tags);
        rdy = mReady;
        for (int w = 0; w < Lanes; w++)
            if (wbValid[w])
                rdy[wbTag[w]] = 1'b1;
        if (accept) begin
            // Ops in program order, so a later op sees the earlier destination
            for (int i = 0; i < Lanes; i++) begin
                eValid[i] = uopValid[i];
                eSqN[i] = mCounter;
                eTagA[i] = mSpec[uopRs0[i]];
                eTagB[i] = mSpec[uopRs1[i]];
                eAvailA[i] = rdy[eTagA[i]];
                eAvailB[i] = rdy[eTagB[i]];
                eTagDst[i] = (uopRd[i] != '0) ? tags[i] : '0;
                eRd[i] = uopRd[i];
                eFu[i] = uopFu[i];
                eImm[i] = uopImm[i];
                if (uopValid[i])
                    mCounter = mCounter + SqN'(1);
                if (uopValid[i] && uopRd[i] != '0) begin
                    mSpec[uopRd[i]] = tags[i];
                    mSpecOwn[tags[i]] = 1'b1;
                    mReady[tags[i]] = 1'b0;
                    rdy[tags[i]] = 1'b0;
                    robRd.push_back(uopRd[i]);
                    robTag.push_back(tags[i]);
                end
            end
            eLoaded = 1'b1;
        end else if (!flush) begin
            for (int i = 0; i < Lanes; i++) begin
                if (!en)
                    eValid[i] = 1'b0;
                for (int w = 0; w < Lanes; w++) begin
                    if (wbValid[w] && wbTag[w] == eTagA[i])
                        eAvailA[i] = 1'b1;
                    if (wbValid[w] && wbTag[w] == eTagB[i])
                        eAvailB[i] = 1'b1;
                end
            end
        end
        for (int i = 0; i < Lanes; i++) begin
            if (comValid[i] && comRd[i] != '0) begin
                prev = mCom[comRd[i]];
                mCom[comRd[i]] = comTag[i];
                mComOwn[comTag[i]] = 1'b1;
                mComOwn[prev] = 1'b0;
                mSpecOwn[prev] = 1'b0;
            end
        end
        for (int w = 0; w < Lanes; w++)
            if (wbValid[w])
                mReady[wbTag[w]] = 1'b1;
        if (flush) begin
            mSpec = mCom;
            mSpecOwn = mComOwn;
            mCounter = flushSqN + SqN'(1);
            eValid = '{default: 1'b0};
            robRd.delete();
            robTag.delete();
        end
    endfunction

    task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (rst)
            resetModel();
        else
            stepModel();
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            checkValue("stall", 32'(expStall()), 32'(stall));
            checkValue("nextSqN", 32'(mCounter), 32'(nextSqN));
            for (int i = 0; i < Lanes; i++) begin
                checkValue($sformatf("outValid[%0d]", i), 32'(eValid[i]), 32'(outValid[i]));
                if (eLoaded) begin
                    checkValue($sformatf("outSqN[%0d]", i), 32'(eSqN[i]), 32'(outSqN[i]));
                    checkValue($sformatf("outTagA[%0d]", i), 32'(eTagA[i]), 32'(outTagA[i]));
                    checkValue($sformatf("outTagB[%0d]", i), 32'(eTagB[i]), 32'(outTagB[i]));
                    checkValue($sformatf("outAvailA[%0d]", i), 32'(eAvailA[i]),
                               32'(outAvailA[i]));
                    checkValue($sformatf("outAvailB[%0d]", i), 32'(eAvailB[i]),
                               32'(outAvailB[i]));
                    checkValue($sformatf("outTagDst[%0d]", i), 32'(eTagDst[i]),
                               32'(outTagDst[i]));
                    checkValue($sformatf("outRd[%0d]", i), 32'(eRd[i]), 32'(outRd[i]));
                    checkValue($sformatf("outFu[%0d]", i), 32'(eFu[i]), 32'(outFu[i]));
                    checkValue($sformatf("outImm[%0d]", i), eImm[i], outImm[i]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2 * TestCycles) begin
            $display("Timeout: run did not finish within %0d cycles", 2 * TestCycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic RegId randReg();
        return RegId'(randBits(4));
    endfunction

    function automatic RegId nzReg();
        RegId r;
        r = randReg();
        return (r == '0) ? RegId'(1) : r;
    endfunction

    task automatic setOp(int lane, RegId rs0, RegId rs1, RegId rd);
        uopValid[lane] <= 1'b1;
        uopRs0[lane] <= rs0;
        uopRs1[lane] <= rs1;
        uopRd[lane] <= rd;
        uopFu[lane] <= FuncUnit'(3'(randBits(3) % 5));
        uopImm[lane] <= randBits(32);
    endtask

    task automatic issueBundle(RegId rd0, RegId rd1);
        @(posedge clk);
        en <= 1'b1;
        setOp(0, randReg(), randReg(), rd0);
        setOp(1, randReg(), randReg(), rd1);
    endtask

    task automatic idle();
        @(posedge clk);
        en <= 1'b0;
        flush <= 1'b0;
        comValid <= '{default: 1'b0};
        wbValid <= '{default: 1'b0};
    endtask

    task automatic finishTest(int errorsBefore);
        tests++;
        $display("Test %s done with %0d errors", testName, errors - errorsBefore);
    endtask

    initial begin
        int start;
        int waited;
        logic stalled;
        Tag heldTag;
        RegId heldRd;
        lfsr = 32'h21ff_2e3e;
        errors = 0;
        checks = 0;
        tests = 0;
        cycles = 0;
        clk = 1'b0;
        rst = 1'b1;
        en = 1'b0;
        flush = 1'b0;
        flushSqN = '0;
        for (int i = 0; i < Lanes; i++) begin
            uopValid[i] = 1'b0;
            uopRs0[i] = '0;
            uopRs1[i] = '0;
            uopRd[i] = '0;
            uopFu[i] = FuAlu;
            uopImm[i] = '0;
            comValid[i] = 1'b0;
            comRd[i] = '0;
            comTag[i] = '0;
            wbValid[i] = 1'b0;
            wbTag[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        testName = "resetMapping";
        start = errors;
        @(negedge clk);
        checkValue("nextSqN after reset", 32'd0, 32'(nextSqN));
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            en <= 1'b1;
            setOp(0, RegId'(4 * k), RegId'(4 * k + 1), '0);
            setOp(1, RegId'(4 * k + 2), RegId'(4 * k + 3), '0);
        end
        idle();
        finishTest(start);

        testName = "renameBypass";
        start = errors;
        repeat (4) issueBundle(randReg(), randReg());
        @(posedge clk);
        setOp(0, randReg(), randReg(), RegId'(7));
        setOp(1, RegId'(7), randReg(), randReg());
        @(posedge clk);
        setOp(0, randReg(), randReg(), '0);
        setOp(1, randReg(), randReg(), nzReg());
        // Empty second lane takes no sequence number
        @(posedge clk);
        setOp(0, randReg(), randReg(), nzReg());
        setOp(1, randReg(), randReg(), '0);
        uopValid[1] <= 1'b0;
        idle();
        finishTest(start);

        testName = "writeback";
        start = errors;
        @(posedge clk);
        en <= 1'b1;
        setOp(0, randReg(), randReg(), RegId'(5));
        setOp(1, RegId'(5), RegId'(5), '0);
        idle();
        @(negedge clk);
        heldTag = eTagDst[0];
        @(posedge clk);
        wbValid[0] <= 1'b1;
        wbTag[0] <= heldTag;
        @(posedge clk);
        wbValid[0] <= 1'b0;
        en <= 1'b1;
        setOp(0, RegId'(5), randReg(), '0);
        setOp(1, randReg(), RegId'(5), '0);
        idle();
        finishTest(start);

        testName = "flushRecovery";
        start = errors;
        issueBundle(nzReg(), nzReg());
        flush <= 1'b1;
        flushSqN <= SqN'(20);
        idle();
        @(negedge clk);
        checkValue("nextSqN after flush", 32'd21, 32'(nextSqN));
        // Registers renamed before the flush read their committed tags again
        @(posedge clk);
        en <= 1'b1;
        setOp(0, RegId'(7), RegId'(5), RegId'(7));
        setOp(1, randReg(), randReg(), RegId'(5));
        idle();
        finishTest(start);

        testName = "stallExhaustion";
        start = errors;
        stalled = 1'b0;
        for (int b = 0; b < 10 && !stalled; b++) begin
            heldRd = nzReg();
            @(posedge clk);
            en <= 1'b1;
            // Second op reads the fresh tag of the first, so that source is not ready
            setOp(0, randReg(), randReg(), heldRd);
            setOp(1, heldRd, randReg(), nzReg());
            @(negedge clk);
            stalled = stall;
        end
        if (!stalled) begin
            errors++;
            $display("Stall never rose after 10 bundles without commit in %s", testName);
        end
        heldTag = eTagA[1];
        @(posedge clk);
        wbValid[0] <= 1'b1;
        wbTag[0] <= heldTag;
        @(posedge clk);
        wbValid[0] <= 1'b0;
        for (int i = 0; i < Lanes; i++) begin
            comValid[i] <= 1'b1;
            comRd[i] <= robRd.pop_front();
            comTag[i] <= robTag.pop_front();
        end
        @(posedge clk);
        comValid <= '{default: 1'b0};
        waited = 0;
        @(negedge clk);
        while (stall && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            errors++;
            $display("Stall stayed high after commits freed tags in %s", testName);
        end
        idle();
        idle();
        finishTest(start);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: Rename.f
common/CoreTypesPkg.sv
common/UopPkg.sv
rename/RenameTable.sv
rename/TagBuffer.sv
rename/Rename.sv
tests/Rename_sva.sv
tests/Rename_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f Rename.f --top-module Rename_tb -o simRename

./obj_dir/simRename > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
